// File: fp_pkg.sv
// Shared types and constants for the Fp2 inverse datapath, imported by every design unit
package fp_pkg;

  // One base-field element, always kept reduced below P_MOD
  typedef logic [15:0] fp_t;

  // Equation number carried with multiplier and subtractor operations
  typedef logic [2:0] tag_t;

  // Base-field prime
  localparam fp_t P_MOD = 16'd65521;

  // Quadratic non-residue, u^2 = BETA
  localparam fp_t BETA = 16'd17;

  // Pipeline depth of fp_mul
  localparam int MUL_LAT = 3;

  // Base-field inverter phases
  typedef enum logic [1:0] {
    IDLE,
    SQUARE,
    MULTIPLY,
    DONE
  } inv_state_t;

  // Fp2 inverse scheduler phases
  typedef enum logic [1:0] {
    LOAD,
    COMPUTE,
    EMIT
  } ctrl_state_t;

endpackage

// File: fp_mul.sv
// Pipelined modular multiplier mod P_MOD with an equation tag, used as a shared scheduler unit
`timescale 1ns/1ps

module fp_mul (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_valid,
  input  fp_pkg::fp_t    i_a,
  input  fp_pkg::fp_t    i_b,
  input  fp_pkg::tag_t   i_tag,
  output logic           o_ready,
  output logic           o_valid,
  output fp_pkg::fp_t    o_res,
  output fp_pkg::tag_t   o_tag,
  input  logic           i_ready
);
  import fp_pkg::*;

  logic [MUL_LAT-1:0]   vld;
  tag_t [MUL_LAT-1:0]   tag_pipe;
  logic [31:0]          s1_prod;
  logic [20:0]          s2_sum;
  logic [20:0]          fold1;
  logic [16:0]          fold2;
  logic                 advance;

  // Whole pipe moves only when the last stage can empty
  assign advance = ~o_valid | i_ready;
  assign o_ready = advance;

  // 2^16 mod P_MOD is 15, so the high half folds back scaled by 15
  assign fold1 = 21'(s1_prod[31:16]) * 21'd15 + 21'(s1_prod[15:0]);
  assign fold2 = 17'(s2_sum[20:16]) * 17'd15 + 17'(s2_sum[15:0]);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[MUL_LAT-2:0], i_valid};
    end
  end

  always_ff @(posedge i_clk) begin
    if (advance) begin
      tag_pipe <= {tag_pipe[MUL_LAT-2:0], i_tag};
      s1_prod  <= 32'(i_a) * 32'(i_b);
      s2_sum   <= fold1;
      // At most one subtraction left after two folds
      o_res    <= (fold2 >= 17'(P_MOD)) ? 16'(fold2 - 17'(P_MOD)) : fold2[15:0];
    end
  end

  assign o_valid = vld[MUL_LAT-1];
  assign o_tag   = tag_pipe[MUL_LAT-1];

endmodule

// File: fp_sub.sv
// Registered modular subtractor mod P_MOD with an equation tag, used as a shared scheduler unit
`timescale 1ns/1ps

module fp_sub (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_valid,
  input  fp_pkg::fp_t    i_a,
  input  fp_pkg::fp_t    i_b,
  input  fp_pkg::tag_t   i_tag,
  output logic           o_ready,
  output logic           o_valid,
  output fp_pkg::fp_t    o_res,
  output fp_pkg::tag_t   o_tag,
  input  logic           i_ready
);
  import fp_pkg::*;

  logic [16:0] diff;

  // Bit 16 set means the difference borrowed
  assign diff    = {1'b0, i_a} - {1'b0, i_b};
  assign o_ready = ~o_valid | i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_res <= diff[16] ? diff[15:0] + P_MOD : diff[15:0];
      o_tag <= i_tag;
    end
  end

endmodule

// File: fp_mnr.sv
// Registered multiply by the non-residue BETA mod P_MOD, serving the E2 step of the scheduler
`timescale 1ns/1ps

module fp_mnr (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_valid,
  input  fp_pkg::fp_t   i_a,
  output logic          o_ready,
  output logic          o_valid,
  output fp_pkg::fp_t   o_res,
  input  logic          i_ready
);
  import fp_pkg::*;

  logic [20:0] scaled;
  logic [16:0] folded;

  // Constant 17 reduces to 16a + a
  assign scaled  = 21'(i_a) * 21'(BETA);
  assign folded  = 17'(scaled[20:16]) * 17'd15 + 17'(scaled[15:0]);
  assign o_ready = ~o_valid | i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_res <= (folded >= 17'(P_MOD)) ? 16'(folded - 17'(P_MOD)) : folded[15:0];
    end
  end

endmodule

// File: fp_inv.sv
// Iterative base-field inverter computing a^(P_MOD-2), the E4 unit of the Fp2 inverse
`timescale 1ns/1ps

module fp_inv (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_valid,
  input  fp_pkg::fp_t   i_a,
  output logic          o_ready,
  output logic          o_valid,
  output fp_pkg::fp_t   o_res,
  input  logic          i_ready
);
  import fp_pkg::*;

  inv_state_t state;
  fp_t        acc;
  fp_t        op;
  fp_t        inv_exp;
  logic [3:0] bit_idx;

  // Single-cycle product with the same two-fold reduction as fp_mul
  function automatic fp_t mod_mul(input fp_t x, input fp_t y);
    logic [31:0] prod;
    logic [20:0] f1;
    logic [16:0] f2;
    prod = 32'(x) * 32'(y);
    f1   = 21'(prod[31:16]) * 21'd15 + 21'(prod[15:0]);
    f2   = 17'(f1[20:16]) * 17'd15 + 17'(f1[15:0]);
    return (f2 >= 17'(P_MOD)) ? 16'(f2 - 17'(P_MOD)) : f2[15:0];
  endfunction

  // Fermat exponent, so zero maps to zero
  assign inv_exp = P_MOD - 16'd2;

  assign o_ready = (state == IDLE);
  assign o_valid = (state == DONE);
  assign o_res   = acc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (i_valid) state <= SQUARE;
        SQUARE: begin
          if (inv_exp[bit_idx]) state <= MULTIPLY;
          else if (bit_idx == 4'd0) state <= DONE;
        end
        MULTIPLY: state <= (bit_idx == 4'd0) ? DONE : SQUARE;
        DONE: if (i_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Left-to-right square and multiply over the exponent bits
  always_ff @(posedge i_clk) begin
    case (state)
      IDLE: begin
        op      <= i_a;
        acc     <= 16'd1;
        bit_idx <= 4'd15;
      end
      SQUARE: begin
        acc <= mod_mul(acc, acc);
        if (!inv_exp[bit_idx] && bit_idx != 4'd0) bit_idx <= bit_idx - 4'd1;
      end
      MULTIPLY: begin
        acc <= mod_mul(acc, op);
        if (bit_idx != 4'd0) bit_idx <= bit_idx - 4'd1;
      end
      default: ;
    endcase
  end

endmodule

// File: fp2_inv_ctrl.sv
// Scheduler for the Fp2 inverse, issuing equations E0 to E7 to the four shared field units
`timescale 1ns/1ps

module fp2_inv_ctrl (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_valid,
  input  fp_pkg::fp_t   i_a0,
  input  fp_pkg::fp_t   i_a1,
  output logic          o_ready,
  output logic          o_valid,
  output fp_pkg::fp_t   o_c0,
  output fp_pkg::fp_t   o_c1,
  input  logic          i_ready,
  output logic          o_mul_valid,
  output fp_pkg::fp_t   o_mul_a,
  output fp_pkg::fp_t   o_mul_b,
  output fp_pkg::tag_t  o_mul_tag,
  input  logic          i_mul_ready,
  input  logic          i_mulr_valid,
  input  fp_pkg::fp_t   i_mulr_res,
  input  fp_pkg::tag_t  i_mulr_tag,
  output logic          o_mulr_ready,
  output logic          o_sub_valid,
  output fp_pkg::fp_t   o_sub_a,
  output fp_pkg::fp_t   o_sub_b,
  output fp_pkg::tag_t  o_sub_tag,
  input  logic          i_sub_ready,
  input  logic          i_subr_valid,
  input  fp_pkg::fp_t   i_subr_res,
  input  fp_pkg::tag_t  i_subr_tag,
  output logic          o_subr_ready,
  output logic          o_mnr_valid,
  output fp_pkg::fp_t   o_mnr_a,
  input  logic          i_mnr_ready,
  input  logic          i_mnrr_valid,
  input  fp_pkg::fp_t   i_mnrr_res,
  output logic          o_mnrr_ready,
  output logic          o_inv_valid,
  output fp_pkg::fp_t   o_inv_a,
  input  logic          i_inv_ready,
  input  logic          i_invr_valid,
  input  fp_pkg::fp_t   i_invr_res,
  output logic          o_invr_ready
);
  import fp_pkg::*;

  ctrl_state_t state;
  fp_t         a0, a1, t0, t1, c0, c1;
  logic [7:0]  eq_issued;
  logic [7:0]  eq_done;
  logic [7:0]  eq_ready;
  logic        res_rdy;
  logic        mul_ok, sub_ok;
  tag_t        mul_sel, sub_sel;

  // An equation may issue once its inputs are done
  always_comb begin
    eq_ready[0] = (state == COMPUTE);
    eq_ready[1] = (state == COMPUTE);
    eq_ready[2] = eq_done[1];
    eq_ready[3] = eq_done[0] & eq_done[2];
    eq_ready[4] = eq_done[3];
    eq_ready[5] = eq_done[4];
    eq_ready[6] = eq_done[4];
    eq_ready[7] = eq_done[6];
    eq_ready    = eq_ready & ~eq_issued;
  end

  // Lowest-numbered ready equation wins each shared unit
  always_comb begin
    mul_ok  = 1'b1;
    mul_sel = 3'd6;
    if (eq_ready[0]) mul_sel = 3'd0;
    else if (eq_ready[1]) mul_sel = 3'd1;
    else if (eq_ready[5]) mul_sel = 3'd5;
    else if (!eq_ready[6]) mul_ok = 1'b0;
    sub_ok  = eq_ready[3] | eq_ready[7];
    sub_sel = eq_ready[3] ? 3'd3 : 3'd7;
  end

  assign o_ready      = (state == LOAD);
  assign o_valid      = (state == EMIT);
  assign o_c0         = c0;
  assign o_c1         = c1;
  assign o_mulr_ready = res_rdy;
  assign o_subr_ready = res_rdy;
  assign o_mnrr_ready = res_rdy;
  assign o_invr_ready = res_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= LOAD;
      eq_issued   <= '0;
      eq_done     <= '0;
      res_rdy     <= 1'b0;
      o_mul_valid <= 1'b0;
      o_sub_valid <= 1'b0;
      o_mnr_valid <= 1'b0;
      o_inv_valid <= 1'b0;
    end else begin
      res_rdy <= 1'b1;
      case (state)
        LOAD: if (i_valid) state <= COMPUTE;
        COMPUTE: if (eq_done[5] && eq_done[7]) state <= EMIT;
        EMIT: begin
          if (i_ready) begin
            state     <= LOAD;
            eq_issued <= '0;
            eq_done   <= '0;
          end
        end
        default: state <= LOAD;
      endcase

      // Issue side, one operation per unit per cycle
      if (!o_mul_valid || i_mul_ready) begin
        o_mul_valid <= mul_ok;
        if (mul_ok) eq_issued[mul_sel] <= 1'b1;
      end
      if (!o_sub_valid || i_sub_ready) begin
        o_sub_valid <= sub_ok;
        if (sub_ok) eq_issued[sub_sel] <= 1'b1;
      end
      if (!o_mnr_valid || i_mnr_ready) begin
        o_mnr_valid <= eq_ready[2];
        if (eq_ready[2]) eq_issued[2] <= 1'b1;
      end
      if (!o_inv_valid || i_inv_ready) begin
        o_inv_valid <= eq_ready[4];
        if (eq_ready[4]) eq_issued[4] <= 1'b1;
      end

      // Result side
      if (i_mulr_valid && res_rdy) eq_done[i_mulr_tag] <= 1'b1;
      if (i_subr_valid && res_rdy) eq_done[i_subr_tag] <= 1'b1;
      if (i_mnrr_valid && res_rdy) eq_done[2] <= 1'b1;
      if (i_invr_valid && res_rdy) eq_done[4] <= 1'b1;
    end
  end

  // Operand latches and temporaries
  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      a0 <= i_a0;
      a1 <= i_a1;
    end
    if (!o_mul_valid || i_mul_ready) begin
      o_mul_tag <= mul_sel;
      o_mul_a   <= (mul_sel == 3'd0 || mul_sel == 3'd5) ? a0 : a1;
      o_mul_b   <= (mul_sel == 3'd0) ? a0 : (mul_sel == 3'd1) ? a1 : t0;
    end
    if (!o_sub_valid || i_sub_ready) begin
      o_sub_tag <= sub_sel;
      // E7 negates t1
      o_sub_a   <= (sub_sel == 3'd3) ? t0 : 16'd0;
      o_sub_b   <= t1;
    end
    if (!o_mnr_valid || i_mnr_ready) o_mnr_a <= t1;
    if (!o_inv_valid || i_inv_ready) o_inv_a <= t0;

    if (i_mulr_valid && res_rdy) begin
      case (i_mulr_tag)
        3'd0: t0 <= i_mulr_res;
        3'd5: c0 <= i_mulr_res;
        // E1 and E6
        default: t1 <= i_mulr_res;
      endcase
    end
    if (i_subr_valid && res_rdy) begin
      if (i_subr_tag == 3'd7) c1 <= i_subr_res;
      else t0 <= i_subr_res;
    end
    if (i_mnrr_valid && res_rdy) t1 <= i_mnrr_res;
    if (i_invr_valid && res_rdy) t0 <= i_invr_res;
  end

endmodule

// File: fp2_inv_top.sv
// Top level of the Fp2 inverse, joining the scheduler to the multiplier, subtractor, mnr and inverter
`timescale 1ns/1ps

module fp2_inv_top (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_valid,
  input  fp_pkg::fp_t   i_a0,
  input  fp_pkg::fp_t   i_a1,
  output logic          o_ready,
  output logic          o_valid,
  output fp_pkg::fp_t   o_c0,
  output fp_pkg::fp_t   o_c1,
  input  logic          i_ready
);
  import fp_pkg::*;

  logic mul_valid, mul_ready, mulr_valid, mulr_ready;
  logic sub_valid, sub_ready, subr_valid, subr_ready;
  logic mnr_valid, mnr_ready, mnrr_valid, mnrr_ready;
  logic inv_valid, inv_ready, invr_valid, invr_ready;
  fp_t  mul_a, mul_b, mulr_res, sub_a, sub_b, subr_res;
  fp_t  mnr_a, mnrr_res, inv_a, invr_res;
  tag_t mul_tag, mulr_tag, sub_tag, subr_tag;

  fp2_inv_ctrl u_ctrl (
    .i_clk, .i_rst, .i_valid, .i_a0, .i_a1, .o_ready,
    .o_valid, .o_c0, .o_c1, .i_ready,
    .o_mul_valid(mul_valid), .o_mul_a(mul_a), .o_mul_b(mul_b), .o_mul_tag(mul_tag),
    .i_mul_ready(mul_ready), .i_mulr_valid(mulr_valid), .i_mulr_res(mulr_res),
    .i_mulr_tag(mulr_tag), .o_mulr_ready(mulr_ready),
    .o_sub_valid(sub_valid), .o_sub_a(sub_a), .o_sub_b(sub_b), .o_sub_tag(sub_tag),
    .i_sub_ready(sub_ready), .i_subr_valid(subr_valid), .i_subr_res(subr_res),
    .i_subr_tag(subr_tag), .o_subr_ready(subr_ready),
    .o_mnr_valid(mnr_valid), .o_mnr_a(mnr_a), .i_mnr_ready(mnr_ready),
    .i_mnrr_valid(mnrr_valid), .i_mnrr_res(mnrr_res), .o_mnrr_ready(mnrr_ready),
    .o_inv_valid(inv_valid), .o_inv_a(inv_a), .i_inv_ready(inv_ready),
    .i_invr_valid(invr_valid), .i_invr_res(invr_res), .o_invr_ready(invr_ready)
  );

  fp_mul u_mul (
    .i_clk, .i_rst, .i_valid(mul_valid), .i_a(mul_a), .i_b(mul_b), .i_tag(mul_tag),
    .o_ready(mul_ready), .o_valid(mulr_valid), .o_res(mulr_res), .o_tag(mulr_tag),
    .i_ready(mulr_ready)
  );

  fp_sub u_sub (
    .i_clk, .i_rst, .i_valid(sub_valid), .i_a(sub_a), .i_b(sub_b), .i_tag(sub_tag),
    .o_ready(sub_ready), .o_valid(subr_valid), .o_res(subr_res), .o_tag(subr_tag),
    .i_ready(subr_ready)
  );

  fp_mnr u_mnr (
    .i_clk, .i_rst, .i_valid(mnr_valid), .i_a(mnr_a), .o_ready(mnr_ready),
    .o_valid(mnrr_valid), .o_res(mnrr_res), .i_ready(mnrr_ready)
  );

  fp_inv u_inv (
    .i_clk, .i_rst, .i_valid(inv_valid), .i_a(inv_a), .o_ready(inv_ready),
    .o_valid(invr_valid), .o_res(invr_res), .i_ready(invr_ready)
  );

endmodule

// File: tb_clk_gen.sv
// Free-running clock source for the Fp2 inverse testbench, period set by PERIOD_NS
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: fp2_inv_asserts.sv
// Concurrent handshake checks, bound onto fp2_inv_top from the testbench
`timescale 1ns/1ps

module fp2_inv_asserts (
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_in_valid,
  input logic        i_in_ready,
  input logic        i_out_valid,
  input fp_pkg::fp_t i_c0,
  input fp_pkg::fp_t i_c1,
  input logic        i_out_ready,
  input logic        i_inv_valid
);
  import fp_pkg::*;

  int fail_count = 0;

  // A stalled result keeps valid and both coefficients
  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_c0) && $stable(i_c1))
  else begin
    $error("result changed while stalled");
    fail_count++;
  end

  a_one_inside: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_valid |-> !i_in_ready)
  else begin
    $error("input ready while a result is pending");
    fail_count++;
  end

  // COMPUTE is the only control phase with both top-level handshakes low
  a_inv_in_compute: assert property (@(posedge i_clk) disable iff (i_rst)
    i_inv_valid |-> !i_in_ready && !i_out_valid)
  else begin
    $error("inverter result outside COMPUTE");
    fail_count++;
  end

  // No result can overtake the first multiplier pass
  a_min_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    i_in_valid && i_in_ready |=> !i_out_valid [*MUL_LAT])
  else begin
    $error("result too early after input");
    fail_count++;
  end

endmodule

// File: fp2_inv_tb.sv
// Self-checking testbench for fp2_inv_top with corner and random elements against a field model
`timescale 1ns/1ps

module fp2_inv_tb;
  import fp_pkg::*;

  localparam int NUM_CORNER      = 8;
  localparam int NUM_RANDOM      = 200;
  localparam int NUM_TESTS       = NUM_CORNER + NUM_RANDOM;
  localparam int CYCLES_PER_TEST = 80;
  localparam int TIMEOUT         = NUM_TESTS * CYCLES_PER_TEST;
  localparam int SEED            = 27;

  // Corner elements as {a0, a1}
  localparam logic [31:0] CORNERS [NUM_CORNER] = '{
    32'h0005_0000, 32'hFFF0_0000, 32'h0000_0001, 32'h0000_FFF0,
    32'hFFF0_FFF0, 32'h0001_FFF0, 32'h0000_0000, 32'h1234_0000
  };

  logic clk;
  logic rst, in_valid, in_ready, out_valid, out_ready;
  fp_t  a0, a1, c0, c1;
  fp_t  op_a0[$], op_a1[$], exp_c0[$], exp_c1[$];
  fp_t  held_c0, held_c1;
  int   sent, received, cycles;
  logic busy, launched, held, emitted, bp_on;

  tb_clk_gen #(.PERIOD_NS(100)) u_clk (.o_clk(clk));

  fp2_inv_top u_fp2_inv_top (
    .i_clk(clk), .i_rst(rst), .i_valid(in_valid), .i_a0(a0), .i_a1(a1), .o_ready(in_ready),
    .o_valid(out_valid), .o_c0(c0), .o_c1(c1), .i_ready(out_ready)
  );

  bind fp2_inv_top fp2_inv_asserts u_asserts (
    .i_clk, .i_rst, .i_in_valid(i_valid), .i_in_ready(o_ready), .i_out_valid(o_valid),
    .i_c0(o_c0), .i_c1(o_c1), .i_out_ready(i_ready), .i_inv_valid(invr_valid)
  );

  function automatic fp_t mod_mult(input fp_t x, input fp_t y);
    logic [31:0] prod;
    prod = 32'(x) * 32'(y);
    return fp_t'(prod % 32'(P_MOD));
  endfunction

  function automatic fp_t mod_diff(input fp_t x, input fp_t y);
    return fp_t'((32'(x) + 32'(P_MOD) - 32'(y)) % 32'(P_MOD));
  endfunction

  // Right-to-left binary exponentiation
  function automatic fp_t mod_pow(input fp_t base, input fp_t e);
    fp_t result;
    fp_t sq;
    result = 16'd1;
    sq     = base;
    for (int i = 0; i < 16; i++) begin
      if (e[i]) result = mod_mult(result, sq);
      sq = mod_mult(sq, sq);
    end
    return result;
  endfunction

  // Inverse via the norm a0^2 - BETA*a1^2 and Fermat
  task automatic push_expected(input fp_t x0, input fp_t x1);
    fp_t norm;
    fp_t norm_inv;
    norm     = mod_diff(mod_mult(x0, x0), mod_mult(BETA, mod_mult(x1, x1)));
    norm_inv = mod_pow(norm, P_MOD - 16'd2);
    exp_c0.push_back(mod_mult(x0, norm_inv));
    exp_c1.push_back(mod_diff(16'd0, mod_mult(x1, norm_inv)));
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] want);
    if (got !== want) begin
      abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    in_valid  = 1'b0;
    a0        = '0;
    a1        = '0;
    out_ready = 1'b0;
    {busy, launched, held, emitted, bp_on} = '0;
    sent      = 0;
    received  = 0;
    for (int i = 0; i < NUM_CORNER; i++) begin
      op_a0.push_back(CORNERS[i][31:16]);
      op_a1.push_back(CORNERS[i][15:0]);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op_a0.push_back(fp_t'($urandom % P_MOD));
      op_a1.push_back(fp_t'($urandom % P_MOD));
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("o_valid after reset", out_valid, 1'b0);
    check_value("o_ready after reset", in_ready, 1'b1);

    while (received < NUM_TESTS) begin
      @(negedge clk);
      if (launched) begin
        busy     = 1'b1;
        launched = 1'b0;
        in_valid = 1'b0;
      end
      if (busy) check_value("o_ready while busy", in_ready, 1'b0);
      if (emitted) check_value("o_ready after output", in_ready, 1'b1);
      emitted = 1'b0;
      // Back-pressure on the last half of the random elements
      bp_on     = (received >= NUM_TESTS - NUM_RANDOM / 2);
      out_ready = bp_on ? 1'($urandom_range(0, 1)) : 1'b1;
      if (held) begin
        check_value("o_valid while stalled", out_valid, 1'b1);
        check_value("o_c0 while stalled", c0, held_c0);
        check_value("o_c1 while stalled", c1, held_c1);
      end
      if (out_valid && !busy) abort_run("Result appeared with no element inside the DUT");
      if (out_valid && out_ready) begin
        check_value("o_c0", c0, exp_c0.pop_front());
        check_value("o_c1", c1, exp_c1.pop_front());
        received++;
        busy    = 1'b0;
        held    = 1'b0;
        emitted = 1'b1;
      end else if (out_valid) begin
        held    = 1'b1;
        held_c0 = c0;
        held_c1 = c1;
      end
      // Next element stays presented until accepted
      if (!in_valid && sent < NUM_TESTS && (!bp_on || $urandom_range(0, 3) != 0)) begin
        in_valid = 1'b1;
        a0       = op_a0[sent];
        a1       = op_a1[sent];
      end
      if (in_valid && in_ready) begin
        push_expected(a0, a1);
        sent++;
        launched = 1'b1;
      end
    end

    // The last result leaves once and the DUT is empty again
    @(negedge clk);
    check_value("o_valid after last result", out_valid, 1'b0);
    check_value("o_ready after last result", in_ready, 1'b1);
    if (u_fp2_inv_top.u_asserts.fail_count != 0) begin
      abort_run("A bound assertion on the DUT handshakes failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // Cycle limit and assertion watch
  initial begin
    cycles = 0;
    forever begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) abort_run("Timeout: the DUT stopped returning results");
      if (u_fp2_inv_top.u_asserts.fail_count != 0) begin
        abort_run("A bound assertion on the DUT handshakes failed");
      end
    end
  end

endmodule

// File: all.f
fp_pkg.sv
fp_mul.sv
fp_sub.sv
fp_mnr.sv
fp_inv.sv
fp2_inv_ctrl.sv
fp2_inv_top.sv
tb_clk_gen.sv
fp2_inv_asserts.sv
fp2_inv_tb.sv

// File: Bender.yml
package:
  name: fp2_inv

sources:
  - files:
      - fp_pkg.sv
      - fp_mul.sv
      - fp_sub.sv
      - fp_mnr.sv
      - fp_inv.sv
      - fp2_inv_ctrl.sv
      - fp2_inv_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - fp2_inv_asserts.sv
      - fp2_inv_tb.sv
